//--- hw/spiCmdPkg.sv
//********************************************************************
// SPI command slave shared definitions
// Byte width, bit counter width, opcode and engine state encodings
//********************************************************************

package spiCmdPkg;

    // One SPI byte
    localparam int byteW = 8;

    // Bit counter inside a byte slot
    localparam int bitCntW = $clog2(byteW);

    // Command opcodes, any other value is a one-byte NOP
    typedef enum logic [byteW-1:0] {
        OP_WRITE = 8'h01,
        OP_READ  = 8'h02,
        OP_ADD   = 8'h03
    } cmdOp;

    // Command engine states
    typedef enum logic [1:0] {
        S_OPCODE,
        S_ADDR,
        S_DATA,
        S_DUMMY
    } engState;

endpackage

//--- hw/mosiDeserializer.sv
//********************************************************************
// MOSI deserializer
// Assembles MSB-first bytes and offers each one by four-phase req/ack
//********************************************************************

module mosiDeserializer (
    input  logic                         i_SCK,
    input  logic                         i_CSn,
    input  logic                         i_mosi,
    input  logic                         i_wrAck,
    output logic                         o_wrReq,
    output logic [spiCmdPkg::byteW-1:0]  o_wrData
);

    import spiCmdPkg::*;

    logic [bitCntW-1:0] bitCnt;
    logic [byteW-1:0]   shiftReg;
    logic               byteDone;

    // Eighth bit of the current slot is on MOSI
    assign byteDone = (bitCnt == bitCntW'(byteW - 1));

    // Bit counter and request flag
    always_ff @(posedge i_SCK or posedge i_CSn) begin
        if (i_CSn) begin
            bitCnt  <= '0;
            o_wrReq <= 1'b0;
        end else begin
            bitCnt <= bitCnt + 1'b1;
            if (byteDone) begin
                o_wrReq <= 1'b1;
            end else if (o_wrReq && i_wrAck) begin
                o_wrReq <= 1'b0;
            end
        end
    end

    // Shift register and hold register
    // The hold register only changes once the previous handshake has ended
    always_ff @(posedge i_SCK) begin
        shiftReg <= {shiftReg[byteW-2:0], i_mosi};
        if (byteDone) begin
            o_wrData <= {shiftReg[byteW-2:0], i_mosi};
        end
    end

endmodule

//--- hw/byteFifo.sv
//********************************************************************
// Byte FIFO
// Circular buffer with four-phase req/ack on write and read sides
//********************************************************************

module byteFifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                         i_SCK,
    input  logic                         i_CSn,
    input  logic                         i_wrReq,
    input  logic [spiCmdPkg::byteW-1:0]  i_wrData,
    input  logic                         i_rdAck,
    output logic                         o_wrAck,
    output logic                         o_rdReq,
    output logic [spiCmdPkg::byteW-1:0]  o_rdData
);

    import spiCmdPkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [byteW-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // New write request, accepted only with room left
    assign push = i_wrReq && !o_wrAck && !full;

    // Read handshake completes when the engine acks
    assign pop = o_rdReq && i_rdAck;

    // Head entry stays put until the engine has acked it
    assign o_rdData = mem[rdPtr];

    always_ff @(posedge i_SCK) begin
        if (push) begin
            mem[wrPtr] <= i_wrData;
        end
    end

    always_ff @(posedge i_SCK or posedge i_CSn) begin
        if (i_CSn) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            o_wrAck <= 1'b0;
            o_rdReq <= 1'b0;
        end else begin
            // Write side, receiver of the handshake
            if (push) begin
                wrPtr   <= wrPtr + 1'b1;
                o_wrAck <= 1'b1;
            end else if (!i_wrReq && o_wrAck) begin
                o_wrAck <= 1'b0;
            end

            // Read side, sender of the handshake
            if (pop) begin
                rdPtr   <= rdPtr + 1'b1;
                o_rdReq <= 1'b0;
            end else if (!o_rdReq && !i_rdAck && !empty) begin
                o_rdReq <= 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/cmdEngine.sv
//********************************************************************
// Command engine
// Decodes WRITE, READ and ADD against a 16-entry register array
//********************************************************************

module cmdEngine #(
    parameter int REG_ADDR_W = 4
) (
    input  logic                         i_SCK,
    input  logic                         i_CSn,
    input  logic                         i_rdReq,
    input  logic [spiCmdPkg::byteW-1:0]  i_rdData,
    input  logic                         i_rspAck,
    output logic                         o_rdAck,
    output logic                         o_rspReq,
    output logic [spiCmdPkg::byteW-1:0]  o_rspData
);

    import spiCmdPkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    // Register array keeps its contents across frames
    logic [byteW-1:0]      regs [NUM_REGS];

    engState               state;
    cmdOp                  opReg;
    logic [REG_ADDR_W-1:0] addrReg;
    logic                  rspSent;
    logic                  take;
    logic                  validOp;
    logic                  rspStart;
    logic                  regWe;
    logic [byteW-1:0]      regWdata;

    // Dummy byte is held back until the response handshake has started
    assign take = i_rdReq && !o_rdAck && ((state != S_DUMMY) || rspSent);

    assign validOp = (i_rdData == OP_WRITE) || (i_rdData == OP_READ) ||
                     (i_rdData == OP_ADD);

    // Response goes out as soon as the address is known,
    // which keeps the READ result in slot n+3
    assign rspStart = (state == S_DUMMY) && !rspSent && !o_rspReq && !i_rspAck;

    assign regWe = take && (state == S_DATA);

    // ADD wraps modulo 256
    assign regWdata = (opReg == OP_ADD) ? regs[addrReg] + i_rdData : i_rdData;

    always_ff @(posedge i_SCK) begin
        if (regWe) begin
            regs[addrReg] <= regWdata;
        end
    end

    // Opcode, address and response payload
    always_ff @(posedge i_SCK) begin
        if (take && (state == S_OPCODE) && validOp) begin
            opReg <= cmdOp'(i_rdData);
        end
        if (take && (state == S_ADDR)) begin
            addrReg <= i_rdData[REG_ADDR_W-1:0];
        end
        if (rspStart) begin
            o_rspData <= regs[addrReg];
        end
    end

    always_ff @(posedge i_SCK or posedge i_CSn) begin
        if (i_CSn) begin
            state    <= S_OPCODE;
            o_rdAck  <= 1'b0;
            o_rspReq <= 1'b0;
            rspSent  <= 1'b0;
        end else begin
            // Receiver side of the FIFO handshake
            if (take) begin
                o_rdAck <= 1'b1;
            end else if (!i_rdReq && o_rdAck) begin
                o_rdAck <= 1'b0;
            end

            // Sender side of the response handshake
            if (rspStart) begin
                o_rspReq <= 1'b1;
            end else if (o_rspReq && i_rspAck) begin
                o_rspReq <= 1'b0;
            end

            if (rspStart) begin
                rspSent <= 1'b1;
            end

            if (take) begin
                case (state)
                    S_OPCODE: begin
                        // Unknown opcodes stay here as a NOP
                        if (validOp) begin
                            state <= S_ADDR;
                        end
                    end
                    S_ADDR: begin
                        state <= (opReg == OP_READ) ? S_DUMMY : S_DATA;
                    end
                    S_DATA: begin
                        state <= S_OPCODE;
                    end
                    S_DUMMY: begin
                        state   <= S_OPCODE;
                        rspSent <= 1'b0;
                    end
                    default: begin
                        state <= S_OPCODE;
                    end
                endcase
            end
        end
    end

endmodule

//--- hw/misoSerializer.sv
//********************************************************************
// MISO serializer
// Sends a pending response byte MSB first in the next byte slot
//********************************************************************

module misoSerializer (
    input  logic                         i_SCK,
    input  logic                         i_CSn,
    input  logic                         i_rspReq,
    input  logic [spiCmdPkg::byteW-1:0]  i_rspData,
    output logic                         o_rspAck,
    output logic                         o_miso,
    output logic                         o_misoOe
);

    import spiCmdPkg::*;

    logic [bitCntW-1:0] bitCnt;
    logic [byteW-1:0]   shiftReg;
    logic [byteW-1:0]   pendData;
    logic               pendValid;
    logic               accept;
    logic               slotEnd;

    assign accept  = i_rspReq && !o_rspAck && !pendValid;
    assign slotEnd = (bitCnt == bitCntW'(byteW - 1));

    always_ff @(posedge i_SCK) begin
        if (accept) begin
            pendData <= i_rspData;
        end
    end

    always_ff @(posedge i_SCK or posedge i_CSn) begin
        if (i_CSn) begin
            bitCnt    <= '0;
            shiftReg  <= '0;
            pendValid <= 1'b0;
            o_rspAck  <= 1'b0;
        end else begin
            bitCnt <= bitCnt + 1'b1;

            // Load on the last edge of a slot, zeros when nothing waits
            if (slotEnd) begin
                shiftReg  <= pendValid ? pendData : '0;
                pendValid <= 1'b0;
            end else begin
                shiftReg <= {shiftReg[byteW-2:0], 1'b0};
            end

            // Accept wins over the slot load clearing the flag
            if (accept) begin
                pendValid <= 1'b1;
                o_rspAck  <= 1'b1;
            end else if (!i_rspReq && o_rspAck) begin
                o_rspAck <= 1'b0;
            end
        end
    end

    assign o_miso   = shiftReg[byteW-1];
    assign o_misoOe = !i_CSn;

endmodule

//--- hw/spiCmdSlave.sv
//********************************************************************
// SPI command slave top level
//********************************************************************

module spiCmdSlave #(
    parameter int FIFO_DEPTH = 4,
    parameter int REG_ADDR_W = 4
) (
    input  logic i_SCK,
    input  logic i_CSn,
    input  logic i_mosi,
    output logic o_miso,
    output logic o_misoOe
);

    import spiCmdPkg::*;

    logic             wrReq;
    logic             wrAck;
    logic [byteW-1:0] wrData;
    logic             rdReq;
    logic             rdAck;
    logic [byteW-1:0] rdData;
    logic             rspReq;
    logic             rspAck;
    logic [byteW-1:0] rspData;

    mosiDeserializer uDeser (
        .i_SCK    (i_SCK),
        .i_CSn    (i_CSn),
        .i_mosi   (i_mosi),
        .i_wrAck  (wrAck),
        .o_wrReq  (wrReq),
        .o_wrData (wrData)
    );

    byteFifo #(.FIFO_DEPTH(FIFO_DEPTH)) uFifo (
        .i_SCK    (i_SCK),
        .i_CSn    (i_CSn),
        .i_wrReq  (wrReq),
        .i_wrData (wrData),
        .i_rdAck  (rdAck),
        .o_wrAck  (wrAck),
        .o_rdReq  (rdReq),
        .o_rdData (rdData)
    );

    cmdEngine #(.REG_ADDR_W(REG_ADDR_W)) uEngine (
        .i_SCK     (i_SCK),
        .i_CSn     (i_CSn),
        .i_rdReq   (rdReq),
        .i_rdData  (rdData),
        .i_rspAck  (rspAck),
        .o_rdAck   (rdAck),
        .o_rspReq  (rspReq),
        .o_rspData (rspData)
    );

    misoSerializer uSer (
        .i_SCK     (i_SCK),
        .i_CSn     (i_CSn),
        .i_rspReq  (rspReq),
        .i_rspData (rspData),
        .o_rspAck  (rspAck),
        .o_miso    (o_miso),
        .o_misoOe  (o_misoOe)
    );

endmodule

//--- bench/spiCmdSlave_assertions.sv
//********************************************************************
// Handshake and MISO output-enable checks for the SPI command slave
//********************************************************************

module spiCmdSlave_assertions (
    input logic i_SCK,
    input logic i_CSn,
    input logic i_misoOe,
    input logic i_wrReq,
    input logic i_wrAck,
    input logic i_rdReq,
    input logic i_rdAck,
    input logic i_rspReq,
    input logic i_rspAck,
    input logic i_fifoFull
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed assertions
    int failCount = 0;

    // Output enable is the inverse of chip select
    oeFollowsCs: assert property (@(posedge i_SCK) i_misoOe == !i_CSn)
        else begin
            $error("o_misoOe differs from inverted CSn");
            failCount++;
        end

    // A request stays up until its acknowledge arrives
    wrReqHeld: assert property (@(posedge i_SCK) disable iff (i_CSn)
        i_wrReq && !i_wrAck |=> i_wrReq)
        else begin
            $error("wrReq dropped before wrAck");
            failCount++;
        end
    rdReqHeld: assert property (@(posedge i_SCK) disable iff (i_CSn)
        i_rdReq && !i_rdAck |=> i_rdReq)
        else begin
            $error("rdReq dropped before rdAck");
            failCount++;
        end
    rspReqHeld: assert property (@(posedge i_SCK) disable iff (i_CSn)
        i_rspReq && !i_rspAck |=> i_rspReq)
        else begin
            $error("rspReq dropped before rspAck");
            failCount++;
        end

    // Acknowledge only answers a live request
    wrAckHasReq: assert property (@(posedge i_SCK) disable iff (i_CSn)
        $rose(i_wrAck) |-> i_wrReq)
        else begin
            $error("wrAck rose without wrReq");
            failCount++;
        end
    rdAckHasReq: assert property (@(posedge i_SCK) disable iff (i_CSn)
        $rose(i_rdAck) |-> i_rdReq)
        else begin
            $error("rdAck rose without rdReq");
            failCount++;
        end
    rspAckHasReq: assert property (@(posedge i_SCK) disable iff (i_CSn)
        $rose(i_rspAck) |-> i_rspReq)
        else begin
            $error("rspAck rose without rspReq");
            failCount++;
        end

    // Back-pressure while the FIFO is full
    noAckWhenFull: assert property (@(posedge i_SCK) disable iff (i_CSn)
        $rose(i_wrAck) |-> !$past(i_fifoFull))
        else begin
            $error("wrAck raised while the FIFO was full");
            failCount++;
        end

endmodule

bind spiCmdSlave spiCmdSlave_assertions uChecks (
    .i_SCK      (i_SCK),
    .i_CSn      (i_CSn),
    .i_misoOe   (o_misoOe),
    .i_wrReq    (wrReq),
    .i_wrAck    (wrAck),
    .i_rdReq    (rdReq),
    .i_rdAck    (rdAck),
    .i_rspReq   (rspReq),
    .i_rspAck   (rspAck),
    .i_fifoFull (uFifo.full)
);

//--- bench/spiCmdSlaveTb.sv
//********************************************************************
// SPI command slave testbench
// Plays frames from the stim file and checks every MISO byte slot
//********************************************************************

module spiCmdSlaveTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_BYTES = 8;
    localparam int OE_TIMEOUT  = 4;

    logic       SCK;
    logic       CSn;
    logic       mosi;
    logic       miso;
    logic       misoOe;
    logic [7:0] mosiBytes [FRAME_BYTES];
    logic [7:0] expBytes [FRAME_BYTES];
    int         errors;
    int         checks;
    int         frames;

    spiCmdSlave #(
        .FIFO_DEPTH (4),
        .REG_ADDR_W (4)
    ) dut_i (
        .i_SCK    (SCK),
        .i_CSn    (CSn),
        .i_mosi   (mosi),
        .o_miso   (miso),
        .o_misoOe (misoOe)
    );

    always #4 SCK = ~SCK;

    // CSn high for a number of cycles, output enable must stay low
    task automatic holdIdle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge SCK);
            if (misoOe !== 1'b0) begin
                $display("Fail %0t: o_misoOe expected 0 got %b", $time, misoOe);
                errors++;
            end
        end
    endtask

    task automatic waitOeLow();
        int cycles;
        cycles = 0;
        @(posedge SCK);
        while (misoOe !== 1'b0 && cycles < OE_TIMEOUT) begin
            @(posedge SCK);
            cycles++;
        end
        if (misoOe !== 1'b0) begin
            $display("o_misoOe still high %0d cycles after CSn rose", OE_TIMEOUT);
            errors++;
        end
    endtask

    // MISO is sampled at the falling edge, before the next MOSI bit goes out
    task automatic sendFrame(input int nBits);
        logic [7:0] rxByte;
        int         k;
        int         slot;
        rxByte = '0;
        for (k = 0; k < nBits; k++) begin
            @(negedge SCK);
            slot   = k / 8;
            rxByte = {rxByte[6:0], miso};
            if (k > 0 && misoOe !== 1'b1) begin
                $display("Fail %0t: o_misoOe expected 1 got %b", $time, misoOe);
                errors++;
            end
            if (k == 0) begin
                CSn = 1'b0;
            end
            mosi = mosiBytes[slot][7 - (k % 8)];
            if (k % 8 == 7) begin
                checks++;
                if (rxByte !== expBytes[slot]) begin
                    $display("Fail %0t: o_miso slot %0d expected %h got %h",
                             $time, slot, expBytes[slot], rxByte);
                    errors++;
                end
            end
        end
        @(negedge SCK);
        CSn  = 1'b1;
        mosi = 1'b0;
        waitOeLow();
    endtask

    initial begin
        string line;
        int    fd;
        int    nFields;
        int    nBits;
        int    seed;
        int    assertFails;
        errors = 0;
        checks = 0;
        frames = 0;
        SCK    = 1'b0;
        CSn    = 1'b1;
        mosi   = 1'b0;
        seed   = $urandom(6921);
        holdIdle(4);

        fd = $fopen("bench/spiCmd_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/spiCmd_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line    = "";
                nFields = $fgets(line, fd);
                // Skip comment and empty lines
                if (line.len() > 1 && line[0] != "#") begin
                    nFields = $sscanf(line,
                        "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", nBits,
                        mosiBytes[0], mosiBytes[1], mosiBytes[2], mosiBytes[3],
                        mosiBytes[4], mosiBytes[5], mosiBytes[6], mosiBytes[7],
                        expBytes[0], expBytes[1], expBytes[2], expBytes[3],
                        expBytes[4], expBytes[5], expBytes[6], expBytes[7]);
                    if (nFields != 17 || nBits < 1 || nBits > 8 * FRAME_BYTES) begin
                        $display("Malformed stimulus line: %s", line);
                        errors++;
                    end else begin
                        sendFrame(nBits);
                        frames++;
                        holdIdle(2 + int'($urandom % 8));
                    end
                end
            end
            $fclose(fd);
        end

        if (frames == 0) begin
            $display("No frames were run");
            errors++;
        end
        assertFails = dut_i.uChecks.failCount;
        $display("Frames %0d, slot checks %0d, errors %0d, assertion failures %0d",
                 frames, checks, errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sources.f
hw/spiCmdPkg.sv
hw/mosiDeserializer.sv
hw/byteFifo.sv
hw/cmdEngine.sv
hw/misoSerializer.sv
hw/spiCmdSlave.sv
bench/spiCmdSlave_assertions.sv
bench/spiCmdSlaveTb.sv

//--- Makefile
# Verilator build and run for the SPI command slave

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module spiCmdSlaveTb \
		-f sources.f --Mdir obj_dir -o simv

# Pass only if the run log holds the pass line
run: compile
	./obj_dir/simv | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/spiCmd_stim.txt
# Bits to send (decimal), 8 MOSI bytes, then 8 expected MISO bytes, all bytes hex
# Opcodes 01 WRITE, 02 READ, 03 ADD, any other byte is a NOP
64 01 05 3C 01 0A F0 00 00  00 00 00 00 00 00 00 00
64 02 05 00 02 0A 00 00 00  00 00 00 3C 00 00 F0 00
64 03 05 11 03 0A 25 00 00  00 00 00 00 00 00 00 00
64 02 05 00 02 0A 00 00 00  00 00 00 4D 00 00 15 00
64 A5 02 05 00 FF 00 00 00  00 00 00 00 4D 00 00 00
64 01 03 7E 02 03 00 00 00  00 00 00 00 00 00 7E 00
64 03 03 85 02 03 00 00 00  00 00 00 00 00 00 03 00
20 02 05 00 00 00 00 00 00  00 00 00 00 00 00 00 00
64 02 05 00 00 00 00 00 00  00 00 00 4D 00 00 00 00
19 03 05 11 00 00 00 00 00  00 00 00 00 00 00 00 00
64 02 15 00 00 00 00 00 00  00 00 00 4D 00 00 00 00
